/* source/lcd_pkg.sv */
package lcd_pkg;

	localparam int h_active = 64;
	localparam int h_front = 4;
	localparam int h_sync = 8;
	localparam int h_back = 8;
	localparam int h_sync_start = h_active + h_front;
	localparam int h_sync_end = h_sync_start + h_sync;
	localparam int h_total = h_sync_end + h_back; // 84 pixel clocks per line

	localparam int v_active = 48;
	localparam int v_front = 2;
	localparam int v_sync = 2;
	localparam int v_back = 3;
	localparam int v_sync_start = v_active + v_front;
	localparam int v_sync_end = v_sync_start + v_sync;
	localparam int v_total = v_sync_end + v_back; // 55 lines per frame

	localparam int win_x0 = 16; // Window is half-open on both axes
	localparam int win_x1 = 48;
	localparam int win_y0 = 8;
	localparam int win_y1 = 40;

	localparam int vram_depth = 1024;
	localparam int vram_aw = 10;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} pixel_t;

	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       hsync_n;
		logic       vsync_n;
		logic       den;
	} screen_pos_t;

	typedef struct packed {
		logic               we;
		logic [vram_aw-1:0] addr;
		pixel_t             wdata;
	} vram_req_t;

	typedef struct packed {
		logic       hsync_n;
		logic       vsync_n;
		logic       den;
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} lcd_out_t;

endpackage

/* source/lcd_timing.sv */
module lcd_timing (
	input  logic                pixel_clk,
	input  logic                rst,
	output lcd_pkg::screen_pos_t pos
);
	import lcd_pkg::*;

	logic [7:0] x_next;
	logic [7:0] y_next;
	logic       x_wrap;
	logic       h_in_sync;
	logic       v_in_sync;
	logic       in_active;

	assign x_wrap = (pos.x == 8'(h_total - 1));

	always_comb begin
		if (x_wrap) begin
			x_next = 8'd0;
			if (pos.y == 8'(v_total - 1)) begin
				y_next = 8'd0;
			end else begin
				y_next = pos.y + 8'd1;
			end
		end else begin
			x_next = pos.x + 8'd1;
			y_next = pos.y;
		end
	end

	// Sync and den are derived from the next position so they line up with x and y
	assign h_in_sync = (x_next >= h_sync_start) && (x_next < h_sync_end);
	assign v_in_sync = (y_next >= v_sync_start) && (y_next < v_sync_end);
	assign in_active = (x_next < h_active) && (y_next < v_active);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pos.x <= 8'(h_total - 1); // Last position of a frame, so (0,0) comes first
			pos.y <= 8'(v_total - 1);
			pos.hsync_n <= 1'b1;
			pos.vsync_n <= 1'b1;
			pos.den <= 1'b0;
		end else begin
			pos.x <= x_next;
			pos.y <= y_next;
			pos.hsync_n <= !h_in_sync;
			pos.vsync_n <= !v_in_sync;
			pos.den <= in_active;
		end
	end

	a_x_range: assert property (@(posedge pixel_clk) disable iff (!rst)
		pos.x < h_total);

endmodule

/* source/image_loader.sv */
module image_loader (
	input  logic              pixel_clk,
	input  logic              rst,
	input  logic              reload,
	input  logic              invert,
	output lcd_pkg::vram_req_t req,
	output logic              req_valid,
	input  logic              grant,
	output logic              loaded
);
	import lcd_pkg::*;

	logic [vram_aw-1:0] addr;
	logic               busy;
	logic               inv_q;
	pixel_t             word;
	logic               last;

	assign last = (addr == vram_aw'(vram_depth - 1));
	assign req_valid = busy;

	always_comb begin
		word.red = addr[4:2]; // Column is addr[4:0], row is addr[9:5]
		word.green = addr[9:7];
		word.blue = addr[2:0] ^ addr[7:5];
		req.we = busy;
		req.addr = addr;
		req.wdata = inv_q ? pixel_t'(~word) : word;
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			addr <= '0;
			busy <= 1'b1; // First fill starts straight out of reset
			loaded <= 1'b0;
			inv_q <= 1'b0;
		end else if (reload) begin
			addr <= '0;
			busy <= 1'b1;
			loaded <= 1'b0;
			inv_q <= invert;
		end else if (busy && grant) begin
			if (last) begin
				busy <= 1'b0;
				loaded <= 1'b1;
			end else begin
				addr <= addr + 1'b1;
			end
		end
	end

	a_no_write_when_loaded: assert property (@(posedge pixel_clk) disable iff (!rst)
		!(req_valid && loaded));

endmodule

/* source/vram_arbiter.sv */
module vram_arbiter (
	input  logic                        pixel_clk,
	input  logic                        rst,
	input  logic                        rd_req,
	input  logic [lcd_pkg::vram_aw-1:0] rd_addr,
	input  lcd_pkg::vram_req_t          wr_req,
	input  logic                        wr_valid,
	output logic                        wr_grant,
	output lcd_pkg::vram_req_t          ram_req
);
	import lcd_pkg::*;

	logic [7:0] starve_cnt;

	assign wr_grant = !rd_req; // Scanout always wins the port

	always_comb begin
		ram_req.wdata = wr_req.wdata;
		if (rd_req) begin
			ram_req.we = 1'b0;
			ram_req.addr = rd_addr;
		end else begin
			ram_req.we = wr_valid && wr_req.we;
			ram_req.addr = wr_req.addr;
		end
	end

	// Counts consecutive cycles a pending write was turned away
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			starve_cnt <= 8'd0;
		end else if (wr_valid && !wr_grant) begin
			starve_cnt <= starve_cnt + 8'd1;
		end else begin
			starve_cnt <= 8'd0;
		end
	end

	a_no_starvation: assert property (@(posedge pixel_clk) disable iff (!rst)
		starve_cnt < h_total);

endmodule

/* source/video_ram.sv */
module video_ram (
	input  logic               pixel_clk,
	input  lcd_pkg::vram_req_t ram_req,
	output lcd_pkg::pixel_t    rdata
);
	import lcd_pkg::*;

	pixel_t mem [vram_depth];

	// Single port, so a write cycle leaves rdata unchanged
	always_ff @(posedge pixel_clk) begin
		if (ram_req.we) begin
			mem[ram_req.addr] <= ram_req.wdata;
		end else begin
			rdata <= mem[ram_req.addr];
		end
	end

endmodule

/* source/scanout.sv */
module scanout (
	input  logic                        pixel_clk,
	input  logic                        rst,
	input  lcd_pkg::screen_pos_t        pos,
	output logic                        rd_req,
	output logic [lcd_pkg::vram_aw-1:0] rd_addr,
	input  lcd_pkg::pixel_t             rdata,
	output lcd_pkg::lcd_out_t           lcd
);
	import lcd_pkg::*;

	logic       in_win;
	logic [7:0] col;
	logic [7:0] row;
	logic [5:0] diag;
	pixel_t     bg;
	logic       win_q;
	pixel_t     bg_q;
	logic       hsync_n_q;
	logic       vsync_n_q;
	logic       den_q;
	pixel_t     color;

	assign in_win = (pos.x >= win_x0) && (pos.x < win_x1) &&
		(pos.y >= win_y0) && (pos.y < win_y1);
	assign col = pos.x - 8'(win_x0);
	assign row = pos.y - 8'(win_y0);

	assign rd_req = in_win;
	assign rd_addr = {row[4:0], col[4:0]}; // Row times 32 plus column

	assign diag = pos.x[5:0] + pos.y[5:0];
	assign bg = pixel_t'({diag, 3'b000}); // Low 9 bits of (x+y)*8

	// Stage 1 waits for the RAM read
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			win_q <= 1'b0;
			hsync_n_q <= 1'b1;
			vsync_n_q <= 1'b1;
			den_q <= 1'b0;
		end else begin
			win_q <= in_win;
			hsync_n_q <= pos.hsync_n;
			vsync_n_q <= pos.vsync_n;
			den_q <= pos.den;
		end
	end

	always_ff @(posedge pixel_clk) begin
		bg_q <= bg;
	end

	assign color = win_q ? rdata : bg_q;

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			lcd <= '{hsync_n: 1'b1, vsync_n: 1'b1, default: '0};
		end else begin
			lcd.hsync_n <= hsync_n_q;
			lcd.vsync_n <= vsync_n_q;
			lcd.den <= den_q;
			lcd.r <= den_q ? {color.red, color.red[2:1]} : 5'd0;
			lcd.g <= den_q ? {color.green, color.green} : 6'd0;
			lcd.b <= den_q ? {color.blue, color.blue[2:1]} : 5'd0;
		end
	end

	a_blank_outside_active: assert property (@(posedge pixel_clk) disable iff (!rst)
		!lcd.den |-> (lcd.r == 5'd0 && lcd.g == 6'd0 && lcd.b == 5'd0));

endmodule

/* source/lcd_frame_top.sv */
module lcd_frame_top (
	input  logic              pixel_clk,
	input  logic              rst,
	input  logic              reload,
	input  logic              invert,
	output logic              loaded,
	output lcd_pkg::lcd_out_t lcd
);
	import lcd_pkg::*;

	screen_pos_t        pos;
	logic               rd_req;
	logic [vram_aw-1:0] rd_addr;
	vram_req_t          ld_req;
	logic               ld_valid;
	logic               ld_grant;
	vram_req_t          ram_req;
	pixel_t             rdata;

	lcd_timing timing0 (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos(pos)
	);

	image_loader loader0 (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.reload(reload),
		.invert(invert),
		.req(ld_req),
		.req_valid(ld_valid),
		.grant(ld_grant),
		.loaded(loaded)
	);

	vram_arbiter arb0 (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.wr_req(ld_req),
		.wr_valid(ld_valid),
		.wr_grant(ld_grant),
		.ram_req(ram_req)
	);

	video_ram vram0 (
		.pixel_clk(pixel_clk),
		.ram_req(ram_req),
		.rdata(rdata)
	);

	scanout scan0 (
		.pixel_clk(pixel_clk),
		.rst(rst),
		.pos(pos),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rdata(rdata),
		.lcd(lcd)
	);

endmodule

/* testbench/tb_clock.sv */
module tb_clock (
	output logic pixel_clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period = 20;
	localparam int reset_cycles = 5;

	initial begin
		pixel_clk = 1'b0;
		forever #half_period pixel_clk = ~pixel_clk;
	end

	initial begin
		rst = 1'b0;
		repeat (reset_cycles) @(posedge pixel_clk);
		#2 rst = 1'b1; // Released off the edge like every other input
	end

endmodule

/* testbench/lcd_frame_tb.sv */
module lcd_frame_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import lcd_pkg::*;

	localparam int frame_cycles = h_total * v_total;
	localparam int timeout_cycles = 6 * frame_cycles + 5;
	localparam int win_pixels = (win_x1 - win_x0) * (win_y1 - win_y0);
	localparam int active_pixels = h_active * v_active;

	logic     pixel_clk;
	logic     rst;
	logic     reload = 1'b0;
	logic     invert = 1'b0;
	logic     loaded;
	lcd_out_t lcd;
	pixel_t   image [vram_depth]; // Expected RAM contents
	bit       win_ok = 1'b0; // Set once the RAM holds a whole image
	int       mx[3] = '{default: h_total - 1}; // Model pos now, one and two clocks back
	int       my[3] = '{default: v_total - 1};
	int       cycles = 0;
	int       h_falls;
	int       v_falls;
	int       win_px;
	int       bg_px;
	int       blank_px;

	tb_clock clk0 (.*);
	lcd_frame_top dut0 (.*);

	always @(posedge pixel_clk) begin
		cycles <= cycles + 1;
		assert (cycles < timeout_cycles)
			else report_failure("Timeout: the tests ran past the cycle limit");
		if (rst) begin
			mx[2] <= mx[1];
			my[2] <= my[1];
			mx[1] <= mx[0];
			my[1] <= my[0];
			mx[0] <= (mx[0] == h_total - 1) ? 0 : mx[0] + 1;
			if (mx[0] == h_total - 1) begin
				my[0] <= (my[0] == v_total - 1) ? 0 : my[0] + 1;
			end
		end
	end

	function automatic bit in_window(input int x, input int y);
		return x >= win_x0 && x < win_x1 && y >= win_y0 && y < win_y1;
	endfunction

	function automatic lcd_out_t expected_lcd(input int x, input int y);
		lcd_out_t    e;
		pixel_t      c;
		logic [15:0] diag;
		diag = 16'((x + y) * 8);
		if (in_window(x, y)) begin
			c = image[(y - win_y0) * 32 + (x - win_x0)];
		end else begin
			c = pixel_t'(diag[8:0]);
		end
		e.hsync_n = !(x >= h_active + h_front && x < h_active + h_front + h_sync);
		e.vsync_n = !(y >= v_active + v_front && y < v_active + v_front + v_sync);
		e.den = x < h_active && y < v_active;
		e.r = e.den ? {c.red, c.red[2:1]} : 5'd0;
		e.g = e.den ? {c.green, c.green} : 6'd0;
		e.b = e.den ? {c.blue, c.blue[2:1]} : 5'd0;
		return e;
	endfunction

	task automatic fill_image(input bit inv);
		pixel_t w;
		for (int a = 0; a < vram_depth; a++) begin
			w.red = 3'((a % 32) / 4);
			w.green = 3'((a / 32) / 4);
			w.blue = 3'(((a % 32) ^ (a / 32)) % 8);
			image[a] = inv ? pixel_t'(~w) : w;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
		report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h (x=%0d y=%0d)",
			name, got, want, mx[2], my[2]));
	endtask

	// lcd now shows the model position from two clocks back
	task automatic tick();
		lcd_out_t e;
		@(posedge pixel_clk);
		#2;
		e = expected_lcd(mx[2], my[2]);
		assert ({lcd.hsync_n, lcd.vsync_n, lcd.den} == {e.hsync_n, e.vsync_n, e.den})
			else mismatch("lcd", lcd, e);
		if (win_ok || !in_window(mx[2], my[2])) begin
			assert (lcd == e) else mismatch("lcd", lcd, e);
		end
	endtask

	task automatic run_frame();
		logic h_prev;
		logic v_prev;
		h_falls = 0;
		v_falls = 0;
		win_px = 0;
		bg_px = 0;
		blank_px = 0;
		for (int i = 0; i < frame_cycles; i++) begin
			h_prev = lcd.hsync_n;
			v_prev = lcd.vsync_n;
			tick();
			h_falls += int'(h_prev && !lcd.hsync_n);
			v_falls += int'(v_prev && !lcd.vsync_n);
			win_px += int'(lcd.den && in_window(mx[2], my[2]));
			bg_px += int'(lcd.den && !in_window(mx[2], my[2]));
			blank_px += int'(!lcd.den);
		end
	endtask

	task automatic wait_loaded(input string what);
		int n;
		n = 0;
		while (!loaded) begin
			tick();
			n++;
			assert (n <= 2 * frame_cycles) else report_failure(what);
		end
		repeat (2) tick(); // Reads after the last write take two clocks to reach lcd
	endtask

	task automatic after_reset();
		@(posedge pixel_clk);
		#2;
		assert (lcd.hsync_n == 1'b1) else mismatch("lcd.hsync_n", lcd.hsync_n, 1);
		assert (lcd.vsync_n == 1'b1) else mismatch("lcd.vsync_n", lcd.vsync_n, 1);
		assert (lcd.den == 1'b0) else mismatch("lcd.den", lcd.den, 0);
		assert (loaded == 1'b0) else mismatch("loaded", loaded, 0);
		@(posedge rst);
		wait_loaded("loaded did not rise within two frames after reset");
	endtask

	task automatic frame_timing();
		int n;
		n = 0;
		while (mx[2] != 0 || my[2] != 0) begin
			tick();
			n++;
			assert (n <= frame_cycles) else report_failure("The model never reached a frame start");
		end
		run_frame();
		assert (h_falls == v_total) else mismatch("hsync_n falls per frame", h_falls, v_total);
		assert (v_falls == 1) else mismatch("vsync_n falls per frame", v_falls, 1);
		assert (win_px + bg_px == active_pixels)
			else mismatch("den cycles per frame", win_px + bg_px, active_pixels);
	endtask

	task automatic window_image();
		win_ok = 1'b1;
		run_frame();
		assert (win_px == win_pixels) else mismatch("window pixels", win_px, win_pixels);
	endtask

	task automatic background_and_blanking();
		run_frame();
		assert (bg_px == active_pixels - win_pixels)
			else mismatch("gradient pixels", bg_px, active_pixels - win_pixels);
		assert (blank_px == frame_cycles - active_pixels)
			else mismatch("blank pixels", blank_px, frame_cycles - active_pixels);
	endtask

	task automatic reload_with_invert();
		win_ok = 1'b0;
		reload = 1'b1;
		invert = 1'b1;
		tick();
		reload = 1'b0;
		invert = 1'b0; // The loader keeps the value it latched with the strobe
		assert (loaded == 1'b0) else mismatch("loaded", loaded, 0);
		fill_image(1'b1);
		wait_loaded("loaded did not rise again within two frames after reload");
		win_ok = 1'b1;
		run_frame();
		assert (win_px == win_pixels) else mismatch("window pixels", win_px, win_pixels);
		assert (h_falls == v_total && v_falls == 1)
			else report_failure("The sync pattern changed after the reload");
	endtask

	initial begin
		fill_image(1'b0);
		after_reset();
		frame_timing();
		window_image();
		background_and_blanking();
		reload_with_invert();
		$display("** PASS **");
		$finish;
	end

endmodule

/* lcd_frame_top.f */
source/lcd_pkg.sv
source/lcd_timing.sv
source/image_loader.sv
source/vram_arbiter.sv
source/video_ram.sv
source/scanout.sv
source/lcd_frame_top.sv
testbench/tb_clock.sv
testbench/lcd_frame_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lcd_frame_tb \
	-f lcd_frame_top.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vlcd_frame_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF -- '** PASS **' && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
